// ==== sim.f ====
+incdir+rtl
rtl/cpuCtrlPkg.sv
rtl/phaseSequencer.sv
rtl/aluGroupDecoder.sv
rtl/loadStoreDecoder.sv
rtl/jumpDecoder.sv
rtl/opxMultiplexer.sv
rtl/controlUnit.sv
bench/controlUnit_chk.sv
bench/controlUnitTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = controlUnitTb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/controlUnitTb.sv ====
`timescale 1ns/100ps
`include "cpuCtrl_settings.svh"

module controlUnitTb;

	localparam int NUM_INSTR = 300;
	localparam int FETCH_TIMEOUT = 8; // cycles allowed for fetch to come back.

	logic                   CLK;
	logic                   RESET;
	logic                   instrStrobe;
	cpuCtrlPkg::instrWord_t instrWord;
	logic                   fetch;
	logic                   execute;
	cpuCtrlPkg::ctrlWord_t  ctrl;
	cpuCtrlPkg::seqCtrl_t   seqCtrl;

	integer seed;
	int     errorCount;
	int     checkCount;
	int     timeoutCount;

	controlUnit controlUnit_i (
		.CLK         (CLK),
		.RESET       (RESET),
		.instrStrobe (instrStrobe),
		.instrWord   (instrWord),
		.fetch       (fetch),
		.execute     (execute),
		.ctrl        (ctrl),
		.seqCtrl     (seqCtrl)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic waitForFetch(output logic ok);
		int cycles;
		cycles = 0;
		while (!fetch && cycles < FETCH_TIMEOUT) begin
			@(negedge CLK);
			cycles++;
		end
		ok = fetch;
		if (!ok) begin
			$display("timeout at %0t: fetch did not return within %0d cycles", $time,
				FETCH_TIMEOUT);
		end
	endtask

	// reference decode of one instruction word into its control and sequencer selectors.
	task automatic modelControls(input cpuCtrlPkg::instrWord_t word,
			output cpuCtrlPkg::ctrlWord_t c, output cpuCtrlPkg::seqCtrl_t s);
		logic [3:0] op;
		logic [1:0] kind;
		logic       store;
		logic       postInc;
		op = word[`OP_MSB:`OP_LSB];
		kind = word[`JMP_KIND_MSB:`JMP_KIND_LSB];
		store = word[`LS_STORE_BIT];
		postInc = word[`LS_POSTINC_BIT];
		c.aluOp = cpuCtrlPkg::ALU_MOV;
		c.aSrc = cpuCtrlPkg::ASRC_REG_A;
		c.bSrc = cpuCtrlPkg::BSRC_REG_B;
		c.byteSel = 1'b0;
		c.dataBus = cpuCtrlPkg::DBUS_REGA_DOUT;
		c.rd = 1'b0;
		c.wr = 1'b0;
		c.regAAddr = cpuCtrlPkg::AADDR_ARGA;
		c.regADin = cpuCtrlPkg::ADIN_DIN;
		c.regSeq = cpuCtrlPkg::SEQ_NONE;
		c.regBAddr = cpuCtrlPkg::BADDR_ARGB;
		s.addrBus = cpuCtrlPkg::ABUS_PC_A;
		s.pcBase = cpuCtrlPkg::PCB_PC_A;
		s.pcOffset = cpuCtrlPkg::PCO_TWO;
		case (word[`GROUP_MSB:`GROUP_LSB])
			cpuCtrlPkg::GROUP_ARITH: begin
				c.aluOp = op;
				c.bSrc = word[`ALU_IMM_BIT] ? cpuCtrlPkg::BSRC_IMM : cpuCtrlPkg::BSRC_REG_B;
				c.regSeq = (op == 4'd15) ? cpuCtrlPkg::SEQ_NONE : cpuCtrlPkg::SEQ_WRITE_A;
				c.dataBus = cpuCtrlPkg::DBUS_ALU_R;
				c.regADin = cpuCtrlPkg::ADIN_ALU_R;
			end
			cpuCtrlPkg::GROUP_LOAD_STORE: begin
				c.aluOp = cpuCtrlPkg::ALU_ADD; // register B plus two.
				c.aSrc = cpuCtrlPkg::ASRC_REG_B;
				c.bSrc = cpuCtrlPkg::BSRC_CONST2;
				c.byteSel = word[`LS_BYTE_BIT];
				c.rd = !store;
				c.wr = store;
				c.dataBus = store ? cpuCtrlPkg::DBUS_REGA_DOUT : cpuCtrlPkg::DBUS_MEM;
				if (store) begin
					c.regSeq = postInc ? cpuCtrlPkg::SEQ_WRITE_B : cpuCtrlPkg::SEQ_NONE;
				end else begin
					c.regSeq = postInc ? cpuCtrlPkg::SEQ_WRITE_AB : cpuCtrlPkg::SEQ_WRITE_A;
				end
				s.addrBus = cpuCtrlPkg::ABUS_REG_B;
			end
			cpuCtrlPkg::GROUP_JUMP: begin
				s.addrBus = cpuCtrlPkg::ABUS_REG_B;
				s.pcBase = cpuCtrlPkg::PCB_REG_B;
				s.pcOffset = cpuCtrlPkg::PCO_ZERO;
				if (kind == 2'd1) begin
					s.addrBus = cpuCtrlPkg::ABUS_PC_A;
					s.pcBase = cpuCtrlPkg::PCB_PC_A;
					s.pcOffset = cpuCtrlPkg::PCO_IMM;
					c.bSrc = cpuCtrlPkg::BSRC_OFFSET;
				end
				if (kind == 2'd2) begin
					c.regAAddr = cpuCtrlPkg::AADDR_LINK;
					c.regADin = cpuCtrlPkg::ADIN_PC;
					c.regSeq = cpuCtrlPkg::SEQ_WRITE_A;
				end
				if (kind == 2'd3) begin
					c.regBAddr = cpuCtrlPkg::BADDR_LINK;
				end
			end
			default: begin
			end
		endcase
	endtask

	initial begin
		logic                   ok;
		int                     n;
		int                     gap;
		cpuCtrlPkg::instrWord_t word;
		cpuCtrlPkg::ctrlWord_t  expCtrl;
		cpuCtrlPkg::seqCtrl_t   expSeq;
		cpuCtrlPkg::seqCtrl_t   defSeq;
		seed = 73607;
		errorCount = 0;
		checkCount = 0;
		timeoutCount = 0;
		RESET = 1'b1;
		instrStrobe = 1'b0;
		instrWord = '0;
		defSeq.addrBus = cpuCtrlPkg::ABUS_PC_A;
		defSeq.pcBase = cpuCtrlPkg::PCB_PC_A;
		defSeq.pcOffset = cpuCtrlPkg::PCO_TWO;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0;
		checkValue("fetch", 32'd1, 32'(fetch));
		checkValue("execute", 32'd0, 32'(execute));
		checkValue("seqCtrl", 32'(defSeq), 32'(seqCtrl));

		for (n = 0; n < NUM_INSTR && timeoutCount == 0; n++) begin
			waitForFetch(ok);
			if (!ok) begin
				timeoutCount++;
			end else begin
				word = 16'($random(seed));
				modelControls(word, expCtrl, expSeq);
				instrStrobe = 1'b1;
				instrWord = word;
				@(negedge CLK);
				checkValue("execute", 32'd1, 32'(execute));
				checkValue("fetch", 32'd0, 32'(fetch));
				checkValue("ir", 32'(word), 32'(controlUnit_i.ir));
				checkValue("ctrl", 32'(expCtrl), 32'(ctrl));
				instrStrobe = 1'($random(seed)); // must be ignored during execute.
				instrWord = 16'($random(seed));
				@(negedge CLK);
				checkValue("fetch", 32'd1, 32'(fetch));
				checkValue("execute", 32'd0, 32'(execute));
				checkValue("ir", 32'(word), 32'(controlUnit_i.ir));
				checkValue("ctrl", 32'(expCtrl), 32'(ctrl));
				checkValue("seqCtrl", 32'(expSeq), 32'(seqCtrl));
				instrStrobe = 1'b0;
				gap = int'($unsigned($random(seed)) % 3);
				repeat (gap) begin
					@(negedge CLK);
					checkValue("fetch", 32'd1, 32'(fetch));
					checkValue("execute", 32'd0, 32'(execute));
					checkValue("seqCtrl", 32'(defSeq), 32'(seqCtrl));
				end
			end
		end

		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== bench/controlUnit_chk.sv ====
`timescale 1ns/100ps

module controlUnit_chk (
	input logic                  CLK,
	input logic                  RESET,
	input logic                  fetch,
	input logic                  execute,
	input cpuCtrlPkg::ctrlWord_t ctrl
);

	phaseExclusive: assert property (@(posedge CLK) disable iff (RESET) !(fetch && execute))
		else $error("fetch and execute are high together");

	// a memory access is either a read or a write.
	accessExclusive: assert property (@(posedge CLK) disable iff (RESET) !(ctrl.rd && ctrl.wr))
		else $error("rd and wr are high together");

	singleExecute: assert property (@(posedge CLK) disable iff (RESET) execute |=> !execute)
		else $error("execute lasted more than one cycle");

endmodule

bind controlUnit controlUnit_chk controlUnit_chk_i (
	.CLK     (CLK),
	.RESET   (RESET),
	.fetch   (fetch),
	.execute (execute),
	.ctrl    (ctrl)
);

// ==== rtl/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit (
	input  logic                   CLK,
	input  logic                   RESET,
	input  logic                   instrStrobe,
	input  cpuCtrlPkg::instrWord_t instrWord,
	output logic                   fetch,
	output logic                   execute,
	output cpuCtrlPkg::ctrlWord_t  ctrl,
	output cpuCtrlPkg::seqCtrl_t   seqCtrl
);

	cpuCtrlPkg::instrWord_t    ir;
	cpuCtrlPkg::aluGroupCtrl_t aluCtrl;
	cpuCtrlPkg::lsGroupCtrl_t  lsCtrl;
	cpuCtrlPkg::jmpGroupCtrl_t jmpCtrl;

	phaseSequencer phaseSequencer_i (
		.CLK         (CLK),
		.RESET       (RESET),
		.instrStrobe (instrStrobe),
		.instrWord   (instrWord),
		.fetch       (fetch),
		.execute     (execute),
		.ir          (ir)
	);

	// all three decoders run in parallel on the same word.
	aluGroupDecoder aluGroupDecoder_i (
		.ir      (ir),
		.aluCtrl (aluCtrl)
	);

	loadStoreDecoder loadStoreDecoder_i (
		.ir     (ir),
		.lsCtrl (lsCtrl)
	);

	jumpDecoder jumpDecoder_i (
		.ir      (ir),
		.jmpCtrl (jmpCtrl)
	);

	opxMultiplexer opxMultiplexer_i (
		.CLK     (CLK),
		.RESET   (RESET),
		.fetch   (fetch),
		.execute (execute),
		.ir      (ir),
		.aluCtrl (aluCtrl),
		.lsCtrl  (lsCtrl),
		.jmpCtrl (jmpCtrl),
		.ctrl    (ctrl),
		.seqCtrl (seqCtrl)
	);

endmodule

// ==== rtl/opxMultiplexer.sv ====
`timescale 1ns/100ps
`include "cpuCtrl_settings.svh"

module opxMultiplexer (
	input  logic                      CLK,
	input  logic                      RESET,
	input  logic                      fetch,
	input  logic                      execute,
	input  cpuCtrlPkg::instrWord_t    ir,
	input  cpuCtrlPkg::aluGroupCtrl_t aluCtrl,
	input  cpuCtrlPkg::lsGroupCtrl_t  lsCtrl,
	input  cpuCtrlPkg::jmpGroupCtrl_t jmpCtrl,
	output cpuCtrlPkg::ctrlWord_t     ctrl,
	output cpuCtrlPkg::seqCtrl_t      seqCtrl
);

	cpuCtrlPkg::group_t   group;
	cpuCtrlPkg::seqCtrl_t seqNext;

	assign group = ir[`GROUP_MSB:`GROUP_LSB];

	always_comb begin
		ctrl = cpuCtrlPkg::CTRL_DEFAULT;
		seqNext = cpuCtrlPkg::SEQ_CTRL_DEFAULT;
		case (group)
			cpuCtrlPkg::GROUP_LOAD_STORE: begin
				ctrl.aluOp = lsCtrl.aluOp;
				ctrl.aSrc = lsCtrl.aSrc;
				ctrl.bSrc = lsCtrl.bSrc;
				ctrl.byteSel = lsCtrl.byteSel;
				ctrl.dataBus = lsCtrl.dataBus;
				ctrl.rd = lsCtrl.rd;
				ctrl.regAAddr = lsCtrl.regAAddr;
				ctrl.regADin = lsCtrl.regADin;
				ctrl.regSeq = lsCtrl.regSeq;
				ctrl.regBAddr = lsCtrl.regBAddr;
				ctrl.wr = lsCtrl.wr;
				seqNext.addrBus = lsCtrl.addrBus;
				seqNext.pcOffset = lsCtrl.pcOffset;
			end
			cpuCtrlPkg::GROUP_JUMP: begin
				// the ALU and the data bus keep their defaults and memory is not accessed.
				ctrl.bSrc = jmpCtrl.bSrc;
				ctrl.regAAddr = jmpCtrl.regAAddr;
				ctrl.regADin = jmpCtrl.regADin;
				ctrl.regSeq = jmpCtrl.regSeq;
				ctrl.regBAddr = jmpCtrl.regBAddr;
				seqNext.addrBus = jmpCtrl.addrBus;
				seqNext.pcBase = jmpCtrl.pcBase;
				seqNext.pcOffset = jmpCtrl.pcOffset;
			end
			cpuCtrlPkg::GROUP_ARITH: begin
				ctrl.aluOp = aluCtrl.aluOp;
				ctrl.aSrc = aluCtrl.aSrc;
				ctrl.bSrc = aluCtrl.bSrc;
				ctrl.regAAddr = aluCtrl.regAAddr;
				ctrl.regBAddr = aluCtrl.regBAddr;
				ctrl.regSeq = aluCtrl.regSeq;
				ctrl.dataBus = cpuCtrlPkg::DBUS_ALU_R; // the result is written back from the ALU.
				ctrl.regADin = cpuCtrlPkg::ADIN_ALU_R;
			end
			default: begin
			end
		endcase
	end

	// the executed instruction's selectors are visible for one fetch cycle only.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			seqCtrl <= cpuCtrlPkg::SEQ_CTRL_DEFAULT;
		end else if (fetch) begin
			seqCtrl <= cpuCtrlPkg::SEQ_CTRL_DEFAULT;
		end else if (execute) begin
			seqCtrl <= seqNext;
		end
	end

endmodule

// ==== rtl/jumpDecoder.sv ====
`timescale 1ns/100ps
`include "cpuCtrl_settings.svh"

module jumpDecoder (
	input  cpuCtrlPkg::instrWord_t    ir,
	output cpuCtrlPkg::jmpGroupCtrl_t jmpCtrl
);

	localparam logic [1:0] KIND_ABSOLUTE = 2'd0;
	localparam logic [1:0] KIND_RELATIVE = 2'd1;
	localparam logic [1:0] KIND_CALL     = 2'd2;
	localparam logic [1:0] KIND_RETURN   = 2'd3;

	logic [1:0] kind;

	assign kind = ir[`JMP_KIND_MSB:`JMP_KIND_LSB];

	always_comb begin
		// the other kinds start from an absolute jump to register B.
		jmpCtrl.addrBus = cpuCtrlPkg::ABUS_REG_B;
		jmpCtrl.bSrc = cpuCtrlPkg::BSRC_REG_B;
		jmpCtrl.pcBase = cpuCtrlPkg::PCB_REG_B;
		jmpCtrl.pcOffset = cpuCtrlPkg::PCO_ZERO;
		jmpCtrl.regSeq = cpuCtrlPkg::SEQ_NONE;
		jmpCtrl.regADin = cpuCtrlPkg::ADIN_DIN;
		jmpCtrl.regAAddr = cpuCtrlPkg::AADDR_ARGA;
		jmpCtrl.regBAddr = cpuCtrlPkg::BADDR_ARGB;

		case (kind)
			KIND_ABSOLUTE: begin
			end
			KIND_RELATIVE: begin
				jmpCtrl.pcBase = cpuCtrlPkg::PCB_PC_A;
				jmpCtrl.pcOffset = cpuCtrlPkg::PCO_IMM;
				jmpCtrl.addrBus = cpuCtrlPkg::ABUS_PC_A;
				jmpCtrl.bSrc = cpuCtrlPkg::BSRC_OFFSET;
			end
			KIND_CALL: begin
				// the return address goes into the link register.
				jmpCtrl.regAAddr = cpuCtrlPkg::AADDR_LINK;
				jmpCtrl.regADin = cpuCtrlPkg::ADIN_PC;
				jmpCtrl.regSeq = cpuCtrlPkg::SEQ_WRITE_A;
			end
			KIND_RETURN: begin
				jmpCtrl.regBAddr = cpuCtrlPkg::BADDR_LINK; // jump target is read from link.
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== rtl/loadStoreDecoder.sv ====
`timescale 1ns/100ps
`include "cpuCtrl_settings.svh"

module loadStoreDecoder (
	input  cpuCtrlPkg::instrWord_t   ir,
	output cpuCtrlPkg::lsGroupCtrl_t lsCtrl
);

	logic isStore;
	logic postInc;

	assign isStore = ir[`LS_STORE_BIT];
	assign postInc = ir[`LS_POSTINC_BIT];

	always_comb begin
		// memory is addressed by register B, and the ALU forms B + 2 for post-increment.
		lsCtrl.addrBus = cpuCtrlPkg::ABUS_REG_B;
		lsCtrl.aluOp = cpuCtrlPkg::ALU_ADD;
		lsCtrl.aSrc = cpuCtrlPkg::ASRC_REG_B;
		lsCtrl.bSrc = cpuCtrlPkg::BSRC_CONST2;
		lsCtrl.byteSel = ir[`LS_BYTE_BIT];
		lsCtrl.pcOffset = cpuCtrlPkg::PCO_TWO;
		lsCtrl.regAAddr = cpuCtrlPkg::AADDR_ARGA;
		lsCtrl.regADin = cpuCtrlPkg::ADIN_DIN;
		lsCtrl.regBAddr = cpuCtrlPkg::BADDR_ARGB;

		if (isStore) begin
			lsCtrl.rd = 1'b0;
			lsCtrl.wr = 1'b1;
			lsCtrl.dataBus = cpuCtrlPkg::DBUS_REGA_DOUT; // register A drives the data bus.
			if (postInc) begin
				lsCtrl.regSeq = cpuCtrlPkg::SEQ_WRITE_B;
			end else begin
				lsCtrl.regSeq = cpuCtrlPkg::SEQ_NONE;
			end
		end else begin
			lsCtrl.rd = 1'b1;
			lsCtrl.wr = 1'b0;
			lsCtrl.dataBus = cpuCtrlPkg::DBUS_MEM;
			if (postInc) begin
				lsCtrl.regSeq = cpuCtrlPkg::SEQ_WRITE_AB;
			end else begin
				lsCtrl.regSeq = cpuCtrlPkg::SEQ_WRITE_A;
			end
		end
	end

endmodule

// ==== rtl/aluGroupDecoder.sv ====
`timescale 1ns/100ps
`include "cpuCtrl_settings.svh"

module aluGroupDecoder (
	input  cpuCtrlPkg::instrWord_t    ir,
	output cpuCtrlPkg::aluGroupCtrl_t aluCtrl
);

	cpuCtrlPkg::aluOpx_t opcode;

	assign opcode = ir[`OP_MSB:`OP_LSB];

	always_comb begin
		aluCtrl.aluOp = opcode; // the opcode goes to the ALU unchanged.
		aluCtrl.aSrc = cpuCtrlPkg::ASRC_REG_A;
		if (ir[`ALU_IMM_BIT]) begin
			aluCtrl.bSrc = cpuCtrlPkg::BSRC_IMM;
		end else begin
			aluCtrl.bSrc = cpuCtrlPkg::BSRC_REG_B;
		end
		aluCtrl.regAAddr = cpuCtrlPkg::AADDR_ARGA;
		aluCtrl.regBAddr = cpuCtrlPkg::BADDR_ARGB;

		// a compare only updates flags, so nothing is written back.
		if (opcode == cpuCtrlPkg::ALU_CMP) begin
			aluCtrl.regSeq = cpuCtrlPkg::SEQ_NONE;
		end else begin
			aluCtrl.regSeq = cpuCtrlPkg::SEQ_WRITE_A;
		end
	end

endmodule

// ==== rtl/phaseSequencer.sv ====
`timescale 1ns/100ps

module phaseSequencer (
	input  logic                   CLK,
	input  logic                   RESET,
	input  logic                   instrStrobe,
	input  cpuCtrlPkg::instrWord_t instrWord,
	output logic                   fetch,
	output logic                   execute,
	output cpuCtrlPkg::instrWord_t ir
);

	typedef enum logic {
		FETCH,
		EXECUTE
	} phase_t;

	phase_t state;
	phase_t stateNext;
	logic   accept;

	assign accept = (state == FETCH) && instrStrobe; // strobes outside fetch are dropped.

	always_comb begin
		stateNext = state;
		case (state)
			FETCH: begin
				if (accept) begin
					stateNext = EXECUTE;
				end
			end
			EXECUTE: stateNext = FETCH; // execute always lasts one cycle.
			default: stateNext = FETCH;
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= FETCH;
			ir <= '0; // a cleared word decodes as a harmless system instruction.
		end else begin
			state <= stateNext;
			if (accept) begin
				ir <= instrWord;
			end
		end
	end

	assign fetch = (state == FETCH);
	assign execute = (state == EXECUTE);

endmodule

// ==== rtl/cpuCtrlPkg.sv ====
`include "cpuCtrl_settings.svh"

package cpuCtrlPkg;

	typedef logic [`INSTR_WIDTH-1:0] instrWord_t;

	typedef logic [1:0] group_t;
	localparam group_t GROUP_SYSTEM     = 2'd0;
	localparam group_t GROUP_LOAD_STORE = 2'd1;
	localparam group_t GROUP_JUMP       = 2'd2;
	localparam group_t GROUP_ARITH      = 2'd3;

	typedef logic [3:0] aluOpx_t; // codes not listed go straight to the ALU.
	localparam aluOpx_t ALU_MOV = 4'd0;
	localparam aluOpx_t ALU_ADD = 4'd1;
	localparam aluOpx_t ALU_CMP = 4'd15;

	typedef logic [2:0] aSrc_t;
	localparam aSrc_t ASRC_REG_A = 3'd0;
	localparam aSrc_t ASRC_PC    = 3'd1;
	localparam aSrc_t ASRC_ZERO  = 3'd2;
	localparam aSrc_t ASRC_REG_B = 3'd3;

	typedef logic [2:0] bSrc_t;
	localparam bSrc_t BSRC_REG_B  = 3'd0;
	localparam bSrc_t BSRC_IMM    = 3'd1;
	localparam bSrc_t BSRC_CONST2 = 3'd2;
	localparam bSrc_t BSRC_OFFSET = 3'd3;

	typedef logic [1:0] dataBus_t;
	localparam dataBus_t DBUS_REGA_DOUT = 2'd0;
	localparam dataBus_t DBUS_ALU_R     = 2'd1;
	localparam dataBus_t DBUS_MEM       = 2'd2;

	typedef logic [1:0] addrBus_t;
	localparam addrBus_t ABUS_PC_A  = 2'd0;
	localparam addrBus_t ABUS_ALU_R = 2'd1;
	localparam addrBus_t ABUS_REG_B = 2'd2;

	typedef logic [1:0] pcBase_t;
	localparam pcBase_t PCB_PC_A  = 2'd0;
	localparam pcBase_t PCB_REG_B = 2'd1;
	localparam pcBase_t PCB_ALU_R = 2'd2;

	typedef logic [1:0] pcOffset_t;
	localparam pcOffset_t PCO_ZERO = 2'd0;
	localparam pcOffset_t PCO_TWO  = 2'd1;
	localparam pcOffset_t PCO_IMM  = 2'd2;

	typedef logic [1:0] regADin_t;
	localparam regADin_t ADIN_DIN   = 2'd0;
	localparam regADin_t ADIN_ALU_R = 2'd1;
	localparam regADin_t ADIN_PC    = 2'd2;

	typedef logic [1:0] regAAddr_t;
	localparam regAAddr_t AADDR_ARGA = 2'd0;
	localparam regAAddr_t AADDR_LINK = 2'd1;
	localparam regAAddr_t AADDR_SP   = 2'd2;

	typedef logic [2:0] regBAddr_t;
	localparam regBAddr_t BADDR_ARGB = 3'd0;
	localparam regBAddr_t BADDR_SP   = 3'd1;
	localparam regBAddr_t BADDR_LINK = 3'd2;

	typedef logic [3:0] regSeq_t;
	localparam regSeq_t SEQ_NONE     = 4'd0;
	localparam regSeq_t SEQ_WRITE_A  = 4'd1;
	localparam regSeq_t SEQ_WRITE_B  = 4'd2;
	localparam regSeq_t SEQ_WRITE_AB = 4'd3;

	typedef struct packed {
		aluOpx_t   aluOp;
		aSrc_t     aSrc;
		bSrc_t     bSrc;
		regAAddr_t regAAddr;
		regBAddr_t regBAddr;
		regSeq_t   regSeq;
	} aluGroupCtrl_t;

	typedef struct packed {
		addrBus_t  addrBus;
		aluOpx_t   aluOp;
		aSrc_t     aSrc;
		bSrc_t     bSrc;
		logic      byteSel; // high for a byte access, low for a word.
		dataBus_t  dataBus;
		pcOffset_t pcOffset;
		logic      rd;
		regSeq_t   regSeq;
		regAAddr_t regAAddr;
		regADin_t  regADin;
		regBAddr_t regBAddr;
		logic      wr;
	} lsGroupCtrl_t;

	typedef struct packed {
		addrBus_t  addrBus;
		bSrc_t     bSrc;
		pcBase_t   pcBase;
		pcOffset_t pcOffset;
		regSeq_t   regSeq;
		regADin_t  regADin;
		regAAddr_t regAAddr;
		regBAddr_t regBAddr;
	} jmpGroupCtrl_t;

	typedef struct packed {
		aluOpx_t   aluOp;
		aSrc_t     aSrc;
		bSrc_t     bSrc;
		logic      byteSel;
		dataBus_t  dataBus;
		logic      rd;
		regAAddr_t regAAddr;
		regADin_t  regADin;
		regSeq_t   regSeq;
		regBAddr_t regBAddr;
		logic      wr;
	} ctrlWord_t;

	typedef struct packed {
		addrBus_t  addrBus;
		pcBase_t   pcBase;
		pcOffset_t pcOffset;
	} seqCtrl_t;

	// every group starts from the controls of the system group.
	localparam ctrlWord_t CTRL_DEFAULT = '{
		aluOp: ALU_MOV, aSrc: ASRC_REG_A, bSrc: BSRC_REG_B, byteSel: 1'b0,
		dataBus: DBUS_REGA_DOUT, rd: 1'b0, regAAddr: AADDR_ARGA, regADin: ADIN_DIN,
		regSeq: SEQ_NONE, regBAddr: BADDR_ARGB, wr: 1'b0
	};

	// fetch always addresses memory from the PC and steps it by one word.
	localparam seqCtrl_t SEQ_CTRL_DEFAULT = '{
		addrBus: ABUS_PC_A, pcBase: PCB_PC_A, pcOffset: PCO_TWO
	};

endpackage

// ==== rtl/cpuCtrl_settings.svh ====
`ifndef CPU_CTRL_SETTINGS_SVH
`define CPU_CTRL_SETTINGS_SVH

// width of one instruction word.
`define INSTR_WIDTH 16

// the group field picks one of the four instruction groups.
`define GROUP_MSB 15
`define GROUP_LSB 14

// only the arithmetic/logic group reads the opcode field.
`define OP_MSB 13
`define OP_LSB 10

// in an arithmetic/logic word this bit selects the immediate as operand B.
`define ALU_IMM_BIT 9

// load/store flag bits.
`define LS_STORE_BIT   13
`define LS_BYTE_BIT    12
`define LS_POSTINC_BIT 11

// jump kind field.
`define JMP_KIND_MSB 13
`define JMP_KIND_LSB 12

`endif
